/* src/l2_ingress_pkg.sv */
// Layer 2 ingress package with stream widths, MAC control constants, enums and beat structs

package l2_ingress_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stream geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int data_w        = 64;  // One word per beat
    localparam int keep_w        = 8;   // Byte enables
    localparam int pfc_classes   = 8;   // Priority classes
    localparam int quanta_step_w = 10;  // Fractional step per quanta tick

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MAC control protocol
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int          mcf_params_bytes  = 18;  // LFC needs 2, PFC needs 18
    localparam logic [15:0] eth_type_mac_ctrl = 16'h8808;
    localparam logic [47:0] mcf_dst_mcast     = 48'h01_80_C2_00_00_01;

    // Pause timers hold quanta scaled by 2^quanta_frac_w
    localparam int quanta_w      = 16;
    localparam int quanta_frac_w = 8;
    localparam int timer_w       = quanta_w + quanta_frac_w;  // 24 bits

    typedef enum logic [15:0] {
        MCF_LFC = 16'h0001,  // 802.3 annex 31B pause
        MCF_PFC = 16'h0101   // 802.3 annex 31D priority pause
    } mcf_opcode_e;

    // Parser position within a frame
    typedef enum logic [1:0] {
        HDR0,    // Destination and start of source
        HDR1,    // Rest of source, EtherType, opcode
        PARAMS,  // Parameter bytes
        SKIP     // Padding and FCS up to last
    } parse_state_e;

    // One receive beat, byte 0 of the beat in data[7:0]
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [keep_w-1:0] keep;
        logic              last;
        logic              user;  // Bad frame flag on last beat
    } axis_beat_t;

    // Accepted control frame, parameter byte i sits in params[8*i +: 8]
    typedef struct packed {
        mcf_opcode_e                   opcode;
        logic [mcf_params_bytes*8-1:0] params;
    } mcf_event_t;

endpackage

/* src/mcf_rx_parser.sv */
// MAC control frame parser that classifies receive frames and extracts pause parameters
`timescale 1ns/1ps

module mcf_rx_parser (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  l2_ingress_pkg::axis_beat_t             rx_beat,
    input  logic                                   rx_valid,
    input  logic                                   rx_lfc_en,
    input  logic [l2_ingress_pkg::pfc_classes-1:0] rx_pfc_en,
    output logic                                   mcf_drop,
    output logic                                   mcf_valid,
    output l2_ingress_pkg::mcf_event_t             mcf
);

    l2_ingress_pkg::parse_state_e state;

    logic [1:0]  param_idx;   // Parameter beat within PARAMS
    logic        dst_ok;      // Beat 0 carried the reserved multicast
    logic        consume_q;   // Current frame is being removed
    logic [1:0]  end_pipe;    // Tracks consumed last beat through filter
    logic [15:0] opcode_q;
    logic [l2_ingress_pkg::mcf_params_bytes*8-1:0] params_q;

    logic [47:0] beat_dst;
    logic [15:0] beat_type;
    logic [15:0] beat_opcode;
    logic [15:0] opcode_cur;
    logic        fc_enabled;
    logic        consume_hit;
    logic        frame_consumed;
    logic        frame_end;
    logic        opcode_ok;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Header fields, network byte order
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign beat_dst = {rx_beat.data[7:0],   rx_beat.data[15:8],  rx_beat.data[23:16],
                       rx_beat.data[31:24], rx_beat.data[39:32], rx_beat.data[47:40]};
    assign beat_type   = {rx_beat.data[39:32], rx_beat.data[47:40]};  // Bytes 12-13
    assign beat_opcode = {rx_beat.data[55:48], rx_beat.data[63:56]};  // Bytes 14-15

    assign fc_enabled = rx_lfc_en || (|rx_pfc_en);

    assign consume_hit = rx_valid && (state == l2_ingress_pkg::HDR1) && dst_ok
                         && (beat_type == l2_ingress_pkg::eth_type_mac_ctrl) && fc_enabled;

    // Decision made on beat 1 is either live or held in consume_q
    assign frame_consumed = consume_hit
                            || (consume_q && (state == l2_ingress_pkg::PARAMS
                                              || state == l2_ingress_pkg::SKIP));

    assign frame_end  = rx_valid && rx_beat.last;
    assign opcode_cur = (state == l2_ingress_pkg::HDR1) ? beat_opcode : opcode_q;

    assign opcode_ok = ((opcode_cur == l2_ingress_pkg::MCF_LFC) && rx_lfc_en)
                       || ((opcode_cur == l2_ingress_pkg::MCF_PFC) && (|rx_pfc_en));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Beat position FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= l2_ingress_pkg::HDR0;
            param_idx <= 2'd0;
            dst_ok    <= 1'b0;
            consume_q <= 1'b0;
        end else if (rx_valid) begin
            case (state)
                l2_ingress_pkg::HDR0: begin
                    dst_ok <= (beat_dst == l2_ingress_pkg::mcf_dst_mcast);
                    if (!rx_beat.last) begin
                        state <= l2_ingress_pkg::HDR1;
                    end
                end
                l2_ingress_pkg::HDR1: begin
                    consume_q <= consume_hit;
                    param_idx <= 2'd0;
                    state     <= rx_beat.last ? l2_ingress_pkg::HDR0 : l2_ingress_pkg::PARAMS;
                end
                l2_ingress_pkg::PARAMS: begin
                    param_idx <= param_idx + 2'd1;
                    if (rx_beat.last) begin
                        state <= l2_ingress_pkg::HDR0;
                    end else if (param_idx == 2'd2) begin
                        state <= l2_ingress_pkg::SKIP;  // All 18 bytes gathered
                    end
                end
                default: begin
                    if (rx_beat.last) begin
                        state <= l2_ingress_pkg::HDR0;
                    end
                end
            endcase
        end
    end

    // Opcode and parameter capture, bytes 16 to 33 of the frame
    always_ff @(posedge clk) begin
        if (rx_valid && state == l2_ingress_pkg::HDR1) begin
            opcode_q <= beat_opcode;
        end
        if (rx_valid && state == l2_ingress_pkg::PARAMS) begin
            case (param_idx)
                2'd0:    params_q[63:0]    <= rx_beat.data;
                2'd1:    params_q[127:64]  <= rx_beat.data;
                default: params_q[143:128] <= rx_beat.data[15:0];
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drop level and event pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcf_drop  <= 1'b0;
            mcf_valid <= 1'b0;
            end_pipe  <= 2'b00;
        end else begin
            end_pipe  <= {end_pipe[0], frame_end && frame_consumed};
            mcf_valid <= frame_end && frame_consumed && opcode_ok && !rx_beat.user;
            // Last beat has left the filter, release
            if (end_pipe[1]) begin
                mcf_drop <= 1'b0;
            end
            if (consume_hit) begin
                mcf_drop <= 1'b1;  // Back to back frame wins over release
            end
        end
    end

    assign mcf.opcode = l2_ingress_pkg::mcf_opcode_e'(opcode_q);
    assign mcf.params = params_q;

endmodule

/* src/pause_quanta_timer.sv */
// Pause quanta timers for LFC and eight PFC classes, driving the pause request levels
`timescale 1ns/1ps

module pause_quanta_timer (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     mcf_valid,
    input  l2_ingress_pkg::mcf_event_t               mcf,
    input  logic                                     rx_lfc_en,
    input  logic                                     rx_lfc_ack,
    input  logic [l2_ingress_pkg::pfc_classes-1:0]   rx_pfc_en,
    input  logic [l2_ingress_pkg::pfc_classes-1:0]   rx_pfc_ack,
    input  logic [l2_ingress_pkg::quanta_step_w-1:0] rx_fc_quanta_step,
    input  logic                                     rx_fc_quanta_clk_en,
    output logic                                     rx_lfc_req,
    output logic [l2_ingress_pkg::pfc_classes-1:0]   rx_pfc_req
);

    // Index pfc_classes is the LFC timer, the lower ones are PFC classes
    logic [l2_ingress_pkg::timer_w-1:0]  cnt [l2_ingress_pkg::pfc_classes+1];
    logic [l2_ingress_pkg::quanta_w-1:0] cls_quanta [l2_ingress_pkg::pfc_classes+1];

    logic [l2_ingress_pkg::pfc_classes:0] cls_en;
    logic [l2_ingress_pkg::pfc_classes:0] cls_ack;
    logic [l2_ingress_pkg::pfc_classes:0] cls_load;
    logic [l2_ingress_pkg::pfc_classes:0] cls_run;
    logic [l2_ingress_pkg::timer_w-1:0]   step_ext;
    logic                                 is_lfc;
    logic                                 is_pfc;
    logic [7:0]                           pfc_vector;

    assign is_lfc     = mcf_valid && (mcf.opcode == l2_ingress_pkg::MCF_LFC);
    assign is_pfc     = mcf_valid && (mcf.opcode == l2_ingress_pkg::MCF_PFC);
    assign pfc_vector = mcf.params[15:8];  // Class enable vector, low byte of bytes 0-1
    assign step_ext   = l2_ingress_pkg::timer_w'(rx_fc_quanta_step);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per timer controls
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        cls_en  = {rx_lfc_en, rx_pfc_en};
        cls_ack = {rx_lfc_ack, rx_pfc_ack};

        cls_load[l2_ingress_pkg::pfc_classes]   = is_lfc;
        cls_quanta[l2_ingress_pkg::pfc_classes] = {mcf.params[7:0], mcf.params[15:8]};

        for (int i = 0; i < l2_ingress_pkg::pfc_classes; i++) begin
            cls_load[i]   = is_pfc && pfc_vector[i];
            // Class i quanta in bytes 2+2i and 3+2i, big-endian
            cls_quanta[i] = {mcf.params[8*(2+2*i) +: 8], mcf.params[8*(3+2*i) +: 8]};
        end

        for (int i = 0; i <= l2_ingress_pkg::pfc_classes; i++) begin
            cls_run[i] = |cnt[i];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i <= l2_ingress_pkg::pfc_classes; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i <= l2_ingress_pkg::pfc_classes; i++) begin
                if (!cls_en[i]) begin
                    cnt[i] <= '0;  // Disabled class drops at once
                end else if (cls_load[i]) begin
                    // Zero quanta gives XON
                    cnt[i] <= {cls_quanta[i], {l2_ingress_pkg::quanta_frac_w{1'b0}}};
                end else if (rx_fc_quanta_clk_en && cls_ack[i] && cls_run[i]) begin
                    if (cnt[i] > step_ext) begin
                        cnt[i] <= cnt[i] - step_ext;
                    end else begin
                        cnt[i] <= '0;  // Saturate
                    end
                end
            end
        end
    end

    assign rx_lfc_req = cls_run[l2_ingress_pkg::pfc_classes];
    assign rx_pfc_req = cls_run[l2_ingress_pkg::pfc_classes-1:0];

endmodule

/* src/rx_frame_filter.sv */
// Receive frame filter, a two stage delay line that removes consumed control frames
`timescale 1ns/1ps

module rx_frame_filter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  l2_ingress_pkg::axis_beat_t in_beat,
    input  logic                       in_valid,
    input  logic                       mcf_drop,
    output l2_ingress_pkg::axis_beat_t out_beat,
    output logic                       out_valid
);

    l2_ingress_pkg::axis_beat_t s1_beat;
    l2_ingress_pkg::axis_beat_t s2_beat;
    logic                       s1_valid;
    logic                       s2_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Valid pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;  // Idle cycles ride along, gaps kept
        end
    end

    // Payload only moves with a valid beat
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_beat <= in_beat;
        end
        if (s1_valid) begin
            s2_beat <= s1_beat;
        end
    end

    // Drop level covers the two beats already in flight at decision time
    assign out_valid = s2_valid && !mcf_drop;
    assign out_beat  = s2_beat;

endmodule

/* src/l2_ingress.sv */
// Layer 2 receive ingress, strips MAC control frames and drives pause requests
`timescale 1ns/1ps

module l2_ingress (
    input  logic                                     clk,
    input  logic                                     rst_n,

    // Receive stream in and out
    input  l2_ingress_pkg::axis_beat_t               rx_beat,
    input  logic                                     rx_valid,
    output l2_ingress_pkg::axis_beat_t               out_beat,
    output logic                                     out_valid,

    // Flow control
    input  logic                                     rx_lfc_en,
    input  logic                                     rx_lfc_ack,
    output logic                                     rx_lfc_req,
    input  logic [l2_ingress_pkg::pfc_classes-1:0]   rx_pfc_en,
    input  logic [l2_ingress_pkg::pfc_classes-1:0]   rx_pfc_ack,
    output logic [l2_ingress_pkg::pfc_classes-1:0]   rx_pfc_req,
    input  logic [l2_ingress_pkg::quanta_step_w-1:0] rx_fc_quanta_step,
    input  logic                                     rx_fc_quanta_clk_en
);

    logic                       mcf_drop;
    logic                       mcf_valid;
    l2_ingress_pkg::mcf_event_t mcf;

    mcf_rx_parser mcf_rx_parser_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_beat   (rx_beat),
        .rx_valid  (rx_valid),
        .rx_lfc_en (rx_lfc_en),
        .rx_pfc_en (rx_pfc_en),
        .mcf_drop  (mcf_drop),
        .mcf_valid (mcf_valid),
        .mcf       (mcf)
    );

    pause_quanta_timer pause_quanta_timer_inst (
        .clk                 (clk),
        .rst_n               (rst_n),
        .mcf_valid           (mcf_valid),
        .mcf                 (mcf),
        .rx_lfc_en           (rx_lfc_en),
        .rx_lfc_ack          (rx_lfc_ack),
        .rx_pfc_en           (rx_pfc_en),
        .rx_pfc_ack          (rx_pfc_ack),
        .rx_fc_quanta_step   (rx_fc_quanta_step),
        .rx_fc_quanta_clk_en (rx_fc_quanta_clk_en),
        .rx_lfc_req          (rx_lfc_req),
        .rx_pfc_req          (rx_pfc_req)
    );

    rx_frame_filter rx_frame_filter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_beat   (rx_beat),
        .in_valid  (rx_valid),
        .mcf_drop  (mcf_drop),
        .out_beat  (out_beat),
        .out_valid (out_valid)
    );

endmodule

/* dv/l2_ingress_checker.sv */
// Bound assertions on control frame removal, the event pulse and the pause requests
`timescale 1ns/1ps

module l2_ingress_checker (
    input logic                                   clk,
    input logic                                   rst_n,
    input l2_ingress_pkg::axis_beat_t             out_beat,
    input logic                                   mcf_drop,
    input logic                                   mcf_valid,
    input logic                                   rx_lfc_req,
    input logic [l2_ingress_pkg::pfc_classes-1:0] rx_pfc_req
);

    int fail_cnt = 0;  // Read by the testbench

    // Timers come out of reset at zero
    req_low_after_reset: assert property (
        @(posedge clk) !rst_n |=> (!rx_lfc_req && (rx_pfc_req == '0))
    ) else begin
        $error("Pause request high in the cycle after reset");
        fail_cnt++;
    end

    // Drop is released only after the consumed last beat sat in the output stage
    drop_spans_frame: assert property (
        @(posedge clk) disable iff (!rst_n) $fell(mcf_drop) |-> $past(out_beat.last)
    ) else begin
        $error("Control frame removal released before its last beat left the filter");
        fail_cnt++;
    end

    event_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) mcf_valid |=> !mcf_valid
    ) else begin
        $error("Control frame event longer than one cycle");
        fail_cnt++;
    end

endmodule

bind l2_ingress l2_ingress_checker checker_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_beat   (out_beat),
    .mcf_drop   (mcf_drop),
    .mcf_valid  (mcf_valid),
    .rx_lfc_req (rx_lfc_req),
    .rx_pfc_req (rx_pfc_req)
);

/* dv/tb_l2_ingress.sv */
// Testbench for the layer 2 ingress stage with frame stimulus, reference models and checks
`timescale 1ns/1ps

module tb_l2_ingress;

    localparam int n_frames       = 12;
    localparam int timeout_cycles = 4 * (n_frames * 16 + 5 * 200);  // Frames plus pause drains

    logic                                     clk   = 1'b0;
    logic                                     rst_n = 1'b0;
    l2_ingress_pkg::axis_beat_t               rx_beat;
    l2_ingress_pkg::axis_beat_t               out_beat;
    logic                                     rx_valid;
    logic                                     out_valid;
    logic                                     rx_lfc_en;
    logic                                     rx_lfc_ack;
    logic                                     rx_lfc_req;
    logic [l2_ingress_pkg::pfc_classes-1:0]   rx_pfc_en;
    logic [l2_ingress_pkg::pfc_classes-1:0]   rx_pfc_ack;
    logic [l2_ingress_pkg::pfc_classes-1:0]   rx_pfc_req;
    logic [l2_ingress_pkg::quanta_step_w-1:0] rx_fc_quanta_step;
    logic                                     rx_fc_quanta_clk_en;

    logic [7:0]                         frm [64];   // Frame under construction, byte 0 first
    l2_ingress_pkg::axis_beat_t         exp_q [$];
    longint                             exp_t [$];  // Negedge where each beat must show
    logic [l2_ingress_pkg::timer_w-1:0] ref_cnt [l2_ingress_pkg::pfc_classes+1];  // Top is LFC
    l2_ingress_pkg::mcf_event_t         pend_ev   = '0;
    l2_ingress_pkg::mcf_event_t         load_ev   = '0;
    logic                               pend_fire = 1'b0;
    logic                               load_now  = 1'b0;
    int                                 cycle_cnt = 0;

    l2_ingress UUT (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_fail(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_beat(input string name, input l2_ingress_pkg::axis_beat_t got,
                              input l2_ingress_pkg::axis_beat_t exp);
        if (got !== exp) begin
            report_fail($sformatf("CHECK FAILED at %0t ns: %s = %h, expected %h",
                                  $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_fail($sformatf("CHECK FAILED at %0t ns: %s = %b, expected %b",
                                  $time, name, got, exp));
        end
    endtask

    task automatic check_req(input string name,
                             input logic [l2_ingress_pkg::pfc_classes-1:0] got,
                             input logic [l2_ingress_pkg::pfc_classes-1:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("CHECK FAILED at %0t ns: %s = %b, expected %b",
                                  $time, name, got, exp));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference models
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // A frame survives unless it is MAC control to the reserved group with flow control on
    function automatic logic ref_filter();
        logic dst_hit;
        logic type_hit;
        dst_hit  = {frm[0], frm[1], frm[2], frm[3], frm[4], frm[5]}
                   == l2_ingress_pkg::mcf_dst_mcast;
        type_hit = {frm[12], frm[13]} == l2_ingress_pkg::eth_type_mac_ctrl;
        return !(dst_hit && type_hit && (rx_lfc_en || (|rx_pfc_en)));
    endfunction

    function automatic logic timers_busy();
        for (int i = 0; i <= l2_ingress_pkg::pfc_classes; i++) begin
            if (ref_cnt[i] != '0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    always @(posedge clk) begin : ref_timer
        logic        en;
        logic        ack;
        logic        load;
        logic [15:0] q;
        for (int i = 0; i <= l2_ingress_pkg::pfc_classes; i++) begin
            if (i == l2_ingress_pkg::pfc_classes) begin
                en   = rx_lfc_en;
                ack  = rx_lfc_ack;
                load = load_now && (load_ev.opcode == l2_ingress_pkg::MCF_LFC);
                q    = {load_ev.params[7:0], load_ev.params[15:8]};
            end else begin
                en   = rx_pfc_en[i];
                ack  = rx_pfc_ack[i];
                load = load_now && (load_ev.opcode == l2_ingress_pkg::MCF_PFC)
                       && load_ev.params[8+i];  // Class vector in byte 1
                q    = {load_ev.params[8*(2+2*i) +: 8], load_ev.params[8*(3+2*i) +: 8]};
            end
            if (!rst_n || !en) begin
                ref_cnt[i] = '0;
            end else if (load) begin
                ref_cnt[i] = {q, {l2_ingress_pkg::quanta_frac_w{1'b0}}};
            end else if (rx_fc_quanta_clk_en && ack && ref_cnt[i] != '0) begin
                ref_cnt[i] = (ref_cnt[i] > rx_fc_quanta_step) ? ref_cnt[i] - rx_fc_quanta_step
                                                              : '0;
            end
        end
        // Event one cycle after the last beat, load one cycle later
        load_now = rst_n && rx_valid && rx_beat.last && pend_fire;
        load_ev  = pend_ev;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Comparison, mid cycle where outputs are settled
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin : compare
        logic                                   exp_valid;
        logic [l2_ingress_pkg::pfc_classes-1:0] exp_pfc;
        if (rst_n) begin
            exp_valid = (exp_t.size() > 0) && (exp_t[0] == $time);
            check_flag("out_valid", out_valid, exp_valid);
            if (exp_valid) begin
                check_beat("out_beat", out_beat, exp_q.pop_front());
                void'(exp_t.pop_front());
            end
            for (int i = 0; i < l2_ingress_pkg::pfc_classes; i++) begin
                exp_pfc[i] = (ref_cnt[i] != '0);
            end
            check_flag("rx_lfc_req", rx_lfc_req,
                       ref_cnt[l2_ingress_pkg::pfc_classes] != '0);
            check_req("rx_pfc_req", rx_pfc_req, exp_pfc);
            if (UUT.checker_inst.fail_cnt != 0) begin
                report_fail("A bound assertion on the DUT failed");
            end
        end
    end

    always @(posedge clk) begin : quanta_tick
        rx_fc_quanta_clk_en <= 1'($urandom_range(1));
    end

    always @(posedge clk) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            report_fail($sformatf("Timeout, run did not end within %0d cycles", timeout_cycles));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic make_frame(input logic ctrl, input logic [15:0] opcode,
                              input logic [7:0] vec, input logic [15:0] quanta);
        for (int i = 0; i < 64; i++) begin
            frm[i] = 8'($urandom);
        end
        frm[0] = 8'h02;  // Unicast
        if (ctrl) begin
            {frm[0], frm[1], frm[2], frm[3], frm[4], frm[5]} = l2_ingress_pkg::mcf_dst_mcast;
            {frm[12], frm[13]} = l2_ingress_pkg::eth_type_mac_ctrl;
            {frm[14], frm[15]} = opcode;
            {frm[16], frm[17]} = (opcode == l2_ingress_pkg::MCF_LFC) ? quanta : {8'h00, vec};
            for (int i = 0; i < l2_ingress_pkg::pfc_classes; i++) begin
                {frm[18+2*i], frm[19+2*i]} = quanta;
            end
        end
    endtask

    // Eight beats of frm, gaps inside only when gappy, idle cycles after
    task automatic send_frame(input logic bad, input logic gappy);
        l2_ingress_pkg::axis_beat_t beat;
        logic                       survive;
        logic [15:0]                op;
        survive = 1'b1;
        op      = {frm[14], frm[15]};
        for (int b = 0; b < 8; b++) begin
            @(posedge clk);
            if (b == 0) begin
                survive = ref_filter();  // Enables as the frame meets them
            end
            for (int k = 0; k < 8; k++) begin
                beat.data[8*k +: 8] = frm[8*b+k];
            end
            beat.keep = '1;
            beat.last = (b == 7);
            beat.user = bad && (b == 7);
            rx_beat  <= beat;
            rx_valid <= 1'b1;
            if (survive) begin
                exp_q.push_back(beat);
                exp_t.push_back($time + 25);  // Two cycles on
            end
            if (b == 7) begin
                pend_fire = !survive && !bad
                            && (((op == l2_ingress_pkg::MCF_LFC) && rx_lfc_en)
                                || ((op == l2_ingress_pkg::MCF_PFC) && (|rx_pfc_en)));
                for (int k = 0; k < l2_ingress_pkg::mcf_params_bytes; k++) begin
                    pend_ev.params[8*k +: 8] = frm[16+k];
                end
                pend_ev.opcode = l2_ingress_pkg::mcf_opcode_e'(op);
            end else if (gappy && $urandom_range(3) == 0) begin
                @(posedge clk);
                rx_valid <= 1'b0;
            end
        end
        repeat ($urandom_range(3) + 1) begin
            @(posedge clk);
            rx_valid <= 1'b0;
        end
    endtask

    task automatic drain_pause();
        repeat (3) @(negedge clk);
        while (timers_busy()) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(76));
        rx_beat             = '0;
        rx_valid            = 1'b0;
        rx_lfc_en           = 1'b1;
        rx_lfc_ack          = 1'b1;
        rx_pfc_en           = '1;
        rx_pfc_ack          = '1;
        rx_fc_quanta_step   = 10'd100;
        rx_fc_quanta_clk_en = 1'b0;
        repeat (3) @(posedge clk);
        rst_n             <= 1'b1;
        rx_fc_quanta_step <= 10'(64 + $urandom_range(191));

        repeat (4) begin
            make_frame(1'b0, 16'h0000, 8'h00, 16'd0);
            send_frame(1'b0, 1'b1);
        end

        // LFC held without ack, then counted down
        rx_lfc_ack <= 1'b0;
        make_frame(1'b1, l2_ingress_pkg::MCF_LFC, 8'h00, 16'd6);
        send_frame(1'b0, 1'b0);
        repeat (20) @(posedge clk);
        rx_lfc_ack <= 1'b1;
        drain_pause();

        // Flow control off, the same kind of frame passes
        rx_lfc_en <= 1'b0;
        rx_pfc_en <= '0;
        make_frame(1'b1, l2_ingress_pkg::MCF_LFC, 8'h00, 16'd6);
        send_frame(1'b0, 1'b0);

        // Only classes 0 and 2 load, then XON on class 0
        rx_lfc_en  <= 1'b1;
        rx_pfc_en  <= 8'h0F;
        rx_pfc_ack <= '0;
        make_frame(1'b1, l2_ingress_pkg::MCF_PFC, 8'hA5, 16'd5);
        send_frame(1'b0, 1'b0);
        make_frame(1'b1, l2_ingress_pkg::MCF_PFC, 8'h01, 16'd0);
        send_frame(1'b0, 1'b0);
        repeat (10) @(posedge clk);
        rx_pfc_ack <= '1;
        drain_pause();

        // Bad frame is dropped and leaves timers alone
        make_frame(1'b1, l2_ingress_pkg::MCF_LFC, 8'h00, 16'd4);
        send_frame(1'b1, 1'b0);

        // Disabling a class clears its request
        rx_pfc_en  <= '1;
        rx_lfc_ack <= 1'b0;
        rx_pfc_ack <= '0;
        make_frame(1'b1, l2_ingress_pkg::MCF_PFC, 8'hFF, 16'd8);
        send_frame(1'b0, 1'b0);
        make_frame(1'b1, l2_ingress_pkg::MCF_LFC, 8'h00, 16'd8);
        send_frame(1'b0, 1'b0);
        rx_pfc_en[2] <= 1'b0;
        repeat (3) @(posedge clk);
        rx_lfc_en <= 1'b0;
        repeat (3) @(posedge clk);
        rx_lfc_en  <= 1'b1;
        rx_pfc_en  <= '1;
        rx_lfc_ack <= 1'b1;
        rx_pfc_ack <= '1;
        drain_pause();

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            report_fail("Run ended with expected beats never delivered");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* sim.f */
src/l2_ingress_pkg.sv
src/mcf_rx_parser.sv
src/pause_quanta_timer.sv
src/rx_frame_filter.sv
src/l2_ingress.sv
dv/l2_ingress_checker.sv
dv/tb_l2_ingress.sv

/* Bender.yml */
package:
  name: l2_ingress

sources:
  - src/l2_ingress_pkg.sv
  - src/mcf_rx_parser.sv
  - src/pause_quanta_timer.sv
  - src/rx_frame_filter.sv
  - src/l2_ingress.sv
  - target: simulation
    files:
      - dv/l2_ingress_checker.sv
      - dv/tb_l2_ingress.sv
